/* design/cart_params.svh */
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Download bus

`define CART_ADDR_W         25
`define CART_DATA_W         16

// All ones marks a cheat-code download
`define CODE_INDEX          8'hFF

////////////////////////////////////////////////////////////////////////////
// Cartridge header locations

`define HDR_REGION_ADDR_A   25'h1F0     // Both bytes hold region chars
`define HDR_REGION_ADDR_B   25'h1F2     // Low byte only
`define HDR_DONE_ADDR       25'h200     // Header fully received

// Serial number words, host order
`define ID_ADDR_0           25'h182
`define ID_ADDR_1           25'h184
`define ID_ADDR_2           25'h186
`define ID_ADDR_3           25'h188
`define ID_ADDR_4           25'h18A

// ID is complete once this word arrives
`define ID_CHECK_ADDR       25'h18C

`endif

/* design/cart_pkg.sv */
`default_nettype none

`include "cart_params.svh"

package cart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Download beat

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} byte_pair_t;

	// Header chars read byte-wise, ROM and cheat data word-wise
	typedef union packed {
		logic [`CART_DATA_W-1:0] word;
		byte_pair_t              bytes;
	} dl_word_u;

	typedef struct packed {
		logic                    wr;    // Single-cycle write qualifier
		logic [`CART_ADDR_W-1:0] addr;
		dl_word_u                data;
	} dl_beat_t;

	////////////////////////////////////////////////////////////////////////////
	// User settings and results

	// Mode 0 header, 1 file extension, 2 or 3 off
	typedef struct packed {
		logic [1:0] mode;
		logic [1:0] prio;       // US>EU>JP, EU>US>JP, US>JP>EU, JP>US>EU
		logic [7:0] ext_index;
	} region_cfg_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic ttn2;
		logic svp;
		logic fmbusy;
	} quirk_t;

	// Fields in record order, flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

/* design/load_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cart_params.svh"

module load_ctrl (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire                         download,
	input  wire [7:0]                   index,
	input  wire cart_pkg::dl_beat_t     host_beat,
	input  wire                         rom_wrack,
	output cart_pkg::dl_beat_t          cart_beat,
	output cart_pkg::dl_beat_t          code_beat,
	output logic                        dl_start,
	output logic                        dl_end,
	output logic                        rom_wr,
	output logic                        ioctl_wait,
	output logic [`CART_ADDR_W-1:0]     rom_size,
	output logic [`CART_DATA_W-1:0]     rom_din
);

	logic                    code_dl;
	logic                    cart_dl;
	logic                    old_dl;
	logic [`CART_ADDR_W-1:0] last_addr;

	assign code_dl = download && (index == `CODE_INDEX);
	assign cart_dl = download && !code_dl;

	// Edges seen in the first cycle of the new level
	assign dl_start = cart_dl && !old_dl;
	assign dl_end   = old_dl && !cart_dl;

	// Memory expects the other byte order
	assign rom_din = {host_beat.data.bytes.lo, host_beat.data.bytes.hi};

	always_comb begin
		cart_beat    = host_beat;
		cart_beat.wr = host_beat.wr && cart_dl;
		code_beat    = host_beat;
		code_beat.wr = host_beat.wr && code_dl;
	end

	////////////////////////////////////////////////////////////////////////////
	// Toggle handshake with external memory

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_dl     <= 1'b0;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			old_dl <= cart_dl;

			if (dl_end)
				ioctl_wait <= 1'b0;

			if (dl_start) begin
				rom_wr <= 1'b0;     // Fresh phase for each load
			end else if (cart_beat.wr) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;
			end else if (ioctl_wait && (rom_wr == rom_wrack)) begin
				ioctl_wait <= 1'b0;     // Memory caught up
			end
		end
	end

	// Size is the address of the final word
	always_ff @(posedge clk_sys) begin
		if (cart_beat.wr)
			last_addr <= cart_beat.addr;
		if (dl_end)
			rom_size <= last_addr;
	end

endmodule

`default_nettype wire

/* design/region_detect.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cart_params.svh"

module region_detect (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire cart_pkg::dl_beat_t     cart_beat,
	input  wire                         dl_start,
	input  wire                         dl_end,
	input  wire cart_pkg::region_cfg_t  cfg,
	output logic [1:0]                  region_req,
	output logic                        region_set
);

	localparam logic [1:0] REGION_JP = 2'd0;
	localparam logic [1:0] REGION_US = 2'd1;
	localparam logic [1:0] REGION_EU = 2'd2;

	logic [2:0] hdr_jue;        // {J, U, E} seen so far
	logic [2:0] seen;
	logic       hdr_ready;
	logic       old_ready;
	logic       ready_rise;
	logic       ready_fall;

	// Any other printable up to 'Z' means Europe
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] jue;
		jue = 3'b000;
		if (ch == "J")
			jue[2] = 1'b1;
		else if (ch == "U")
			jue[1] = 1'b1;
		else if (ch >= "0" && ch <= "Z")
			jue[0] = 1'b1;
		return jue;
	endfunction

	// First listed region is also the fallback
	function automatic logic [1:0] resolve(input logic [1:0] prio, input logic [2:0] jue);
		logic j;
		logic u;
		logic e;
		logic [1:0] r;
		{j, u, e} = jue;
		case (prio)
			2'd0:    r = u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			2'd1:    r = e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			2'd2:    r = u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			default: r = j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
		return r;
	endfunction

	always_comb begin
		seen = 3'b000;
		if (cart_beat.wr && cart_beat.addr == `HDR_REGION_ADDR_A)
			seen = classify(cart_beat.data.bytes.lo) | classify(cart_beat.data.bytes.hi);
		else if (cart_beat.wr && cart_beat.addr == `HDR_REGION_ADDR_B)
			seen = classify(cart_beat.data.bytes.lo);
	end

	assign ready_rise = hdr_ready && !old_ready;
	assign ready_fall = old_ready && !hdr_ready;

	////////////////////////////////////////////////////////////////////////////
	// Header scan and region request

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hdr_jue    <= 3'b000;
			hdr_ready  <= 1'b0;
			old_ready  <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr_ready;

			if (dl_start)
				hdr_jue <= 3'b000;
			else
				hdr_jue <= hdr_jue | seen;

			if (dl_end)
				hdr_ready <= 1'b0;
			else if (cart_beat.wr && cart_beat.addr == `HDR_DONE_ADDR)
				hdr_ready <= 1'b1;

			if (ready_rise) begin
				case (cfg.mode)
					2'd0: begin     // From header chars
						region_set <= 1'b1;
						region_req <= resolve(cfg.prio, hdr_jue);
					end
					2'd1: begin     // From file extension
						region_set <= |cfg.ext_index;
						region_req <= cfg.ext_index[7:6];
					end
					default: ;      // Not forced
				endcase
			end

			if (ready_fall)
				region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/quirk_match.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cart_params.svh"

module quirk_match (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire cart_pkg::dl_beat_t     cart_beat,
	input  wire                         dl_start,
	output cart_pkg::quirk_t            quirks
);

	logic [63:0] cart_id;       // Eight ASCII chars, first char on top
	logic [15:0] id_swap;

	// Known titles that need special handling
	function automatic cart_pkg::quirk_t quirk_lookup(input logic [63:0] id);
		cart_pkg::quirk_t q;
		q = '0;
		case (id)
			// Save RAM mapped despite header
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				q.sram = 1'b1;

			// Serial EEPROM saves
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				q.eeprom = 1'b1;

			"T-113016": q.noram = 1'b1;     // Fake RAM check
			"T-89016 ": q.fifo  = 1'b1;
			"T-574023", "T-574013": q.pier = 1'b1;
			"TITAN002": q.ttn2 = 1'b1;
			"MK-1229 ", "G-7001  ": q.svp = 1'b1;   // DSP cartridge

			// Relies on FM busy flag
			"T-35036 ", "T-25073 ", "MK-1137-":
				q.fmbusy = 1'b1;

			default: ;
		endcase
		return q;
	endfunction

	assign id_swap = {cart_beat.data.bytes.lo, cart_beat.data.bytes.hi};

	////////////////////////////////////////////////////////////////////////////
	// ID assembly from byte-swapped words

	always_ff @(posedge clk_sys) begin
		if (cart_beat.wr) begin
			case (cart_beat.addr)
				`ID_ADDR_0: cart_id[63:56] <= cart_beat.data.bytes.hi;
				`ID_ADDR_1: cart_id[55:40] <= id_swap;
				`ID_ADDR_2: cart_id[39:24] <= id_swap;
				`ID_ADDR_3: cart_id[23:8]  <= id_swap;
				`ID_ADDR_4: cart_id[7:0]   <= cart_beat.data.bytes.lo;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			quirks <= '0;
		else if (dl_start)
			quirks <= '0;
		else if (cart_beat.wr && cart_beat.addr == `ID_CHECK_ADDR)
			quirks <= quirks | quirk_lookup(cart_id);
	end

endmodule

`default_nettype wire

/* design/cheat_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module cheat_loader (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire cart_pkg::dl_beat_t     code_beat,
	output cart_pkg::cheat_code_t       code,
	output logic                        code_valid
);

	// Low word first for every field
	always_ff @(posedge clk_sys) begin
		if (code_beat.wr) begin
			case (code_beat.addr[3:0])
				4'd0:  code.flags[15:0]    <= code_beat.data.word;
				4'd2:  code.flags[31:16]   <= code_beat.data.word;
				4'd4:  code.address[15:0]  <= code_beat.data.word;
				4'd6:  code.address[31:16] <= code_beat.data.word;
				4'd8:  code.compare[15:0]  <= code_beat.data.word;
				4'd10: code.compare[31:16] <= code_beat.data.word;
				4'd12: code.replace[15:0]  <= code_beat.data.word;
				4'd14: code.replace[31:16] <= code_beat.data.word;
				default: ;
			endcase
		end
	end

	// Last word of a record completes it
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			code_valid <= 1'b0;
		else
			code_valid <= code_beat.wr && (code_beat.addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

/* design/cart_loader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cart_params.svh"

module cart_loader (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire                         download,
	input  wire [7:0]                   index,
	input  wire cart_pkg::dl_beat_t     host_beat,
	input  wire cart_pkg::region_cfg_t  cfg,
	input  wire                         rom_wrack,
	output wire                         rom_wr,
	output wire                         ioctl_wait,
	output wire [`CART_ADDR_W-1:0]      rom_size,
	output wire [`CART_DATA_W-1:0]      rom_din,
	output wire [1:0]                   region_req,
	output wire                         region_set,
	output wire cart_pkg::quirk_t       quirks,
	output wire cart_pkg::cheat_code_t  code,
	output wire                         code_valid
);

	wire cart_pkg::dl_beat_t cart_beat;     // ROM download only
	wire cart_pkg::dl_beat_t code_beat;     // Cheat download only
	wire                     dl_start;
	wire                     dl_end;

	////////////////////////////////////////////////////////////////////////////
	// Download control and ROM handshake

	load_ctrl u_load_ctrl (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.download   (download),
		.index      (index),
		.host_beat  (host_beat),
		.rom_wrack  (rom_wrack),
		.cart_beat  (cart_beat),
		.code_beat  (code_beat),
		.dl_start   (dl_start),
		.dl_end     (dl_end),
		.rom_wr     (rom_wr),
		.ioctl_wait (ioctl_wait),
		.rom_size   (rom_size),
		.rom_din    (rom_din)
	);

	////////////////////////////////////////////////////////////////////////////
	// Header decoders

	region_detect u_region_detect (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cart_beat  (cart_beat),
		.dl_start   (dl_start),
		.dl_end     (dl_end),
		.cfg        (cfg),
		.region_req (region_req),
		.region_set (region_set)
	);

	quirk_match u_quirk_match (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cart_beat  (cart_beat),
		.dl_start   (dl_start),
		.quirks     (quirks)
	);

	cheat_loader u_cheat_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.code_beat  (code_beat),
		.code       (code),
		.code_valid (code_valid)
	);

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 20;       // 40 ns period
	localparam int RESET_CYCLES = 16;

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* verif/cart_loader_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_loader_chk (
	input wire                      clk_sys,
	input wire                      rst_n,
	input wire cart_pkg::dl_beat_t  host_beat,
	input wire cart_pkg::dl_beat_t  cart_beat,
	input wire                      dl_start,
	input wire                      ioctl_wait,
	input wire                      rom_wr,
	input wire                      code_valid
);

	int unsigned violations = 0;    // Failed assertions so far

	////////////////////////////////////////////////////////////////////////////
	// ROM handshake

	// Host holds off while memory is busy
	a_no_write_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		host_beat.wr |-> !ioctl_wait)
	else begin
		violations = violations + 1;
		$error("Host write while ioctl_wait is high");
	end

	// Phase moves only on a cart write, or back to 0 at load start
	a_rom_wr_cause: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(rom_wr != $past(rom_wr)) |-> $past(cart_beat.wr || dl_start))
	else begin
		violations = violations + 1;
		$error("rom_wr changed without a cart write");
	end

	a_code_valid_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		code_valid |=> !code_valid)
	else begin
		violations = violations + 1;
		$error("code_valid held for more than one cycle");
	end

endmodule

bind cart_loader cart_loader_chk chk (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.host_beat  (host_beat),
	.cart_beat  (cart_beat),
	.dl_start   (dl_start),
	.ioctl_wait (ioctl_wait),
	.rom_wr     (rom_wr),
	.code_valid (code_valid)
);

`default_nettype wire

/* verif/cart_loader_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cart_params.svh"

module cart_loader_tb;

	localparam logic [7:0] ROM_INDEX = 8'h01;
	localparam logic [1:0] REG_JP    = 2'd0;
	localparam logic [1:0] REG_US    = 2'd1;
	localparam logic [1:0] REG_EU    = 2'd2;
	// Loads take about 1100 cycles even with 4-cycle acks
	localparam int TIMEOUT_CYCLES = 4000;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    download;
	logic [7:0]              index;
	cart_pkg::dl_beat_t      host_beat;
	cart_pkg::region_cfg_t   cfg;
	logic                    rom_wrack = 1'b0;
	logic                    rom_wr;
	logic                    ioctl_wait;
	logic [`CART_ADDR_W-1:0] rom_size;
	logic [`CART_DATA_W-1:0] rom_din;
	logic [1:0]              region_req;
	logic                    region_set;
	cart_pkg::quirk_t        quirks;
	cart_pkg::cheat_code_t   code;
	logic                    code_valid;

	integer     seed = 32'h5c13_e139;
	integer     ack_draw;
	logic [2:0] ack_delay = 3'd0;
	int         cycle_count = 0;
	string      test_name = "reset";

	tb_clock clock_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	cart_loader UUT (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.download   (download),
		.index      (index),
		.host_beat  (host_beat),
		.cfg        (cfg),
		.rom_wrack  (rom_wrack),
		.rom_wr     (rom_wr),
		.ioctl_wait (ioctl_wait),
		.rom_size   (rom_size),
		.rom_din    (rom_din),
		.region_req (region_req),
		.region_set (region_set),
		.quirks     (quirks),
		.code       (code),
		.code_valid (code_valid)
	);

	// Memory echoes the request phase 1 to 4 cycles after it sees it
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_wrack <= 1'b0;
			ack_delay <= 3'd0;
		end else if (ack_delay != 3'd0) begin
			if (ack_delay == 3'd1)
				rom_wrack <= rom_wr;
			ack_delay <= ack_delay - 3'd1;
		end else if (rom_wr != rom_wrack) begin
			ack_draw = $random(seed);
			ack_delay <= 3'd1 + {1'b0, ack_draw[1:0]};
		end
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: %s did not finish within %0d cycles", test_name, TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "Run stopped by timeout");
		end else if (UUT.chk.violations != 0) begin
			$display("A bound assertion failed during %s", test_name);
			$display("TESTS FAILED");
			$fatal(1, "Run stopped by assertion failure");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic fail_value(input string what, input string expected, input string actual);
		$display("FAIL %s %s: expected %s actual %s", test_name, what, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			fail_value(what, $sformatf("%b", expected), $sformatf("%b", actual));
	endtask

	task automatic check_word(input string what, input cart_pkg::dl_word_u expected,
		input cart_pkg::dl_word_u actual);
		if (actual !== expected)
			fail_value(what, $sformatf("%h", expected.word), $sformatf("%h", actual.word));
	endtask

	task automatic check_size(input string what, input logic [`CART_ADDR_W-1:0] expected,
		input logic [`CART_ADDR_W-1:0] actual);
		if (actual !== expected)
			fail_value(what, $sformatf("%h", expected), $sformatf("%h", actual));
	endtask

	task automatic check_region(input string what, input logic [1:0] exp_req,
		input logic exp_set, input logic [1:0] act_req, input logic act_set);
		if (act_req !== exp_req || act_set !== exp_set)
			fail_value(what, $sformatf("req %0d set %b", exp_req, exp_set),
				$sformatf("req %0d set %b", act_req, act_set));
	endtask

	task automatic check_quirks(input string what, input cart_pkg::quirk_t expected,
		input cart_pkg::quirk_t actual);
		if (actual !== expected)
			fail_value(what, $sformatf("%b", expected), $sformatf("%b", actual));
	endtask

	task automatic check_code(input string what, input cart_pkg::cheat_code_t expected,
		input cart_pkg::cheat_code_t actual);
		if (actual !== expected)
			fail_value(what, $sformatf("%h", expected), $sformatf("%h", actual));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host side stimulus

	task automatic host_write(input logic [`CART_ADDR_W-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		host_beat.wr        <= 1'b1;
		host_beat.addr      <= addr;
		host_beat.data.word <= data;
		@(posedge clk_sys);
		host_beat.wr <= 1'b0;       // Data stays on the bus
	endtask

	// ROM word with the full handshake
	task automatic cart_write(input logic [`CART_ADDR_W-1:0] addr, input logic [15:0] data);
		logic prev_wr;
		prev_wr = rom_wr;
		host_write(addr, data);
		@(negedge clk_sys);
		check_bit("ioctl_wait raised", 1'b1, ioctl_wait);
		while (ioctl_wait)
			@(negedge clk_sys);
		check_bit("rom_wr toggled once", ~prev_wr, rom_wr);
		check_word("rom_din", {data[7:0], data[15:8]}, rom_din);
	endtask

	task automatic start_download(input logic [7:0] idx);
		@(posedge clk_sys);
		index    <= idx;
		download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		while (rom_wrack !== rom_wr)        // Memory follows the phase reset
			@(negedge clk_sys);
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		download <= 1'b0;
		@(posedge clk_sys);     // dl_end edge
		@(negedge clk_sys);
	endtask

	// Region codes index the seen bits: 0 JP, 1 US, 2 EU
	function automatic logic [1:0] expected_region(input logic [1:0] prio,
		input logic [2:0] seen);
		logic [1:0] order [3];
		logic [1:0] pick;
		logic       found;
		int         i;
		case (prio)
			2'd0:    order = '{REG_US, REG_EU, REG_JP};
			2'd1:    order = '{REG_EU, REG_US, REG_JP};
			2'd2:    order = '{REG_US, REG_JP, REG_EU};
			default: order = '{REG_JP, REG_US, REG_EU};
		endcase
		pick  = order[0];       // Fallback with no valid chars
		found = 1'b0;
		for (i = 0; i < 3; i++) begin
			if (!found && seen[order[i]]) begin
				pick  = order[i];
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	// ROM bytes 'h183 to 'h18A hold the ID; host words carry the odd byte high
	function automatic logic [15:0] id_word(input logic [63:0] id, input int slot);
		logic [7:0] rom_byte [2];
		int         off;
		int         b;
		for (b = 0; b < 2; b++) begin
			off = 2 + 2 * slot + b;     // From 'h180
			rom_byte[b] = (off >= 3 && off <= 10) ? id[63 - 8 * (off - 3) -: 8] : 8'h20;
		end
		return {rom_byte[1], rom_byte[0]};
	endfunction

	task automatic region_case(input string label, input cart_pkg::region_cfg_t setting,
		input logic [15:0] word_a, input logic [15:0] word_b,
		input logic [1:0] exp_req, input logic exp_set);
		@(posedge clk_sys);
		cfg <= setting;
		start_download(ROM_INDEX);
		check_bit({label, " rom_wr at start"}, 1'b0, rom_wr);
		cart_write(`HDR_REGION_ADDR_A, word_a);
		cart_write(`HDR_REGION_ADDR_B, word_b);
		cart_write(`HDR_DONE_ADDR, 16'h0000);
		check_region(label, exp_req, exp_set, region_req, region_set);
		end_download();
		@(negedge clk_sys);     // Set drops a cycle after dl_end
		check_bit({label, " set cleared"}, 1'b0, region_set);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_rom_handshake();
		logic [15:0] data;
		logic        prev_wr;
		int          i;
		test_name = "test_rom_handshake";
		start_download(ROM_INDEX);
		for (i = 0; i < 19; i++) begin
			data = $random(seed);
			cart_write(2 * i, data);
		end
		// Last word is still waiting on memory when the load ends
		data    = $random(seed);
		prev_wr = rom_wr;
		host_write(25'd38, data);
		end_download();
		check_bit("ioctl_wait cleared by end", 1'b0, ioctl_wait);
		check_bit("last rom_wr toggle", ~prev_wr, rom_wr);
		check_word("last rom_din", {data[7:0], data[15:8]}, rom_din);
		check_size("rom_size", 25'd38, rom_size);
	endtask

	task automatic test_region_header();
		cart_pkg::region_cfg_t setting;
		int                    p;
		test_name = "test_region_header";
		for (p = 0; p < 4; p++) begin
			setting = '{mode: 2'd0, prio: p[1:0], ext_index: 8'h00};
			region_case($sformatf("prio %0d JU", p), setting, "JU", "  ",
				expected_region(p[1:0], 3'b011), 1'b1);
			region_case($sformatf("prio %0d E", p), setting, "  ", " E",
				expected_region(p[1:0], 3'b100), 1'b1);
			// High byte at 'h1F2 is not a region char
			region_case($sformatf("prio %0d none", p), setting, "ab", "E ",
				expected_region(p[1:0], 3'b000), 1'b1);
		end
	endtask

	task automatic test_region_ext();
		logic [7:0] exts [5];
		int         i;
		test_name = "test_region_ext";
		exts = '{8'h40, 8'h80, 8'hC3, 8'h01, 8'h00};
		for (i = 0; i < 5; i++)
			region_case($sformatf("ext %h", exts[i]), '{2'd1, 2'd0, exts[i]}, "JU", "  ",
				exts[i][7:6], exts[i] != 8'h00);
		// Disabled keeps the last request, which was JP
		region_case("mode 2", '{2'd2, 2'd0, 8'h80}, "JU", "  ", REG_JP, 1'b0);
		region_case("mode 3", '{2'd3, 2'd1, 8'h80}, "JU", "  ", REG_JP, 1'b0);
	endtask

	task automatic test_quirks();
		logic [63:0]             ids [4];
		cart_pkg::quirk_t        expect_q [4];
		logic [`CART_ADDR_W-1:0] id_addr [5];
		int                      k;
		int                      i;
		test_name = "test_quirks";
		ids      = '{"T-081276", "G-4060  ", "MK-1229 ", "X-999999"};
		expect_q = '{default: '0};
		expect_q[0].sram   = 1'b1;
		expect_q[1].eeprom = 1'b1;
		expect_q[2].svp    = 1'b1;
		id_addr = '{`ID_ADDR_0, `ID_ADDR_1, `ID_ADDR_2, `ID_ADDR_3, `ID_ADDR_4};
		for (k = 0; k < 5; k++) begin
			start_download(ROM_INDEX);
			check_quirks("cleared at start", '0, quirks);
			if (k < 4) begin
				for (i = 0; i < 5; i++)
					cart_write(id_addr[i], id_word(ids[k], i));
				cart_write(`ID_CHECK_ADDR, 16'h0000);
				check_quirks($sformatf("ID %s", ids[k]), expect_q[k], quirks);
			end
			end_download();
		end
	endtask

	task automatic test_cheat();
		logic [15:0]           words [8];
		cart_pkg::cheat_code_t expected;
		logic                  wr_before;
		int                    i;
		test_name = "test_cheat";
		for (i = 0; i < 8; i++)
			words[i] = $random(seed);
		expected.flags   = {words[1], words[0]};
		expected.address = {words[3], words[2]};
		expected.compare = {words[5], words[4]};
		expected.replace = {words[7], words[6]};
		wr_before = rom_wr;
		start_download(`CODE_INDEX);
		for (i = 0; i < 8; i++)
			host_write(25'h40 + 2 * i, words[i]);
		@(negedge clk_sys);
		while (!code_valid)
			@(negedge clk_sys);
		check_code("record on strobe", expected, code);
		@(negedge clk_sys);
		check_bit("strobe length", 1'b0, code_valid);
		end_download();
		check_code("record held", expected, code);
		check_bit("rom_wr untouched", wr_before, rom_wr);
		check_bit("ioctl_wait idle", 1'b0, ioctl_wait);
	endtask

	initial begin
		download  = 1'b0;
		index     = 8'h00;
		host_beat = '0;
		cfg       = '0;
		while (rst_n !== 1'b1)
			@(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("rom_wr", 1'b0, rom_wr);
		check_bit("ioctl_wait", 1'b0, ioctl_wait);
		check_bit("region_set", 1'b0, region_set);
		check_bit("code_valid", 1'b0, code_valid);
		check_quirks("quirks", '0, quirks);

		test_rom_handshake();
		test_region_header();
		test_region_ext();
		test_quirks();
		test_cheat();

		@(negedge clk_sys);
		if (UUT.chk.violations == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("TESTS FAILED");
			$fatal(1, "Bound assertions reported errors");
		end
	end

endmodule

`default_nettype wire

/* cart_loader.f */
+incdir+design
design/cart_pkg.sv
design/load_ctrl.sv
design/region_detect.sv
design/quirk_match.sv
design/cheat_loader.sv
design/cart_loader.sv
verif/tb_clock.sv
verif/cart_loader_chk.sv
verif/cart_loader_tb.sv
